// File: common/rename_defines.svh
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// Micro-ops renamed per cycle
`define RN_WIDTH 2

// Writeback ports from the execution units
`define RN_WB 2

`define RN_ARCH_REGS 32
`define RN_REG_BITS 5

`define RN_TAGS 64
`define RN_TAG_BITS 6

`define RN_SQN_BITS 6

// Width of pc and immediate
`define RN_XLEN 32

`endif

// File: common/uopPkg.sv
`include "rename_defines.svh"

package uopPkg;

    typedef enum logic [1:0] {
        FU_INT,
        FU_LSU,
        FU_BRANCH,
        FU_MUL
    } fuKind;

    // Micro-op as it leaves the decoder
    typedef struct packed {
        logic                    valid;
        logic [`RN_XLEN-1:0]     pc;
        logic [`RN_XLEN-1:0]     imm;
        logic [`RN_REG_BITS-1:0] rs0;
        logic [`RN_REG_BITS-1:0] rs1;
        logic [`RN_REG_BITS-1:0] rd;
        fuKind                   fu;
        logic [3:0]              opcode;
        // Only looked at for LSU ops
        logic                    isStore;
    } decodedUop;

    // Micro-op after renaming, validity is carried beside it
    typedef struct packed {
        logic [`RN_XLEN-1:0]     pc;
        logic [`RN_XLEN-1:0]     imm;
        fuKind                   fu;
        logic [3:0]              opcode;
        logic [`RN_REG_BITS-1:0] nmDst;

        // Source operands
        logic [`RN_TAG_BITS-1:0] tagA;
        logic [`RN_TAG_BITS-1:0] tagB;
        logic                    availA;
        logic                    availB;

        // Zero when nmDst is r0
        logic [`RN_TAG_BITS-1:0] tagDst;

        logic [`RN_SQN_BITS-1:0] sqN;
        // Loads issued before this op
        logic [`RN_SQN_BITS-1:0] loadSqN;
        // Youngest store at or before this op
        logic [`RN_SQN_BITS-1:0] storeSqN;
    } renamedUop;

endpackage

// File: common/backendPkg.sv
`include "rename_defines.svh"

package backendPkg;

    // Retired op from the reorder buffer
    typedef struct packed {
        logic                    valid;
        logic [`RN_REG_BITS-1:0] nmDst;
        logic [`RN_TAG_BITS-1:0] tagDst;
        logic [`RN_SQN_BITS-1:0] sqN;
    } commitUop;

    // Result broadcast from an execution unit
    typedef struct packed {
        logic                    valid;
        logic [`RN_TAG_BITS-1:0] tagDst;
    } wbResult;

    // Mispredicted branch, counters restart after it
    typedef struct packed {
        logic                    taken;
        logic [`RN_SQN_BITS-1:0] sqN;
        logic [`RN_SQN_BITS-1:0] loadSqN;
        logic [`RN_SQN_BITS-1:0] storeSqN;
    } branchRecovery;

endpackage

// File: rename/renameTable.sv
`timescale 1ns/100ps
`include "rename_defines.svh"

module renameTable (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    mispred,

    input  logic [`RN_REG_BITS-1:0] lookupRegs [2*`RN_WIDTH],
    output logic [`RN_TAG_BITS-1:0] lookupTags [2*`RN_WIDTH],
    output logic [2*`RN_WIDTH-1:0]  lookupAvail,

    input  logic [`RN_WIDTH-1:0]    issueValid,
    input  logic [`RN_REG_BITS-1:0] issueRegs [`RN_WIDTH],
    input  logic [`RN_TAG_BITS-1:0] issueTags [`RN_WIDTH],

    input  logic [`RN_WIDTH-1:0]    commitValid,
    input  logic [`RN_REG_BITS-1:0] commitRegs [`RN_WIDTH],
    input  logic [`RN_TAG_BITS-1:0] commitTags [`RN_WIDTH],
    output logic [`RN_TAG_BITS-1:0] commitPrevTags [`RN_WIDTH],

    input  backendPkg::wbResult     wb [`RN_WB]
);

    // Speculative map written at rename
    logic [`RN_TAG_BITS-1:0]  specTag [`RN_ARCH_REGS];
    logic [`RN_ARCH_REGS-1:0] specAvail;
    // Committed map written at retirement
    logic [`RN_TAG_BITS-1:0]  comTag [`RN_ARCH_REGS];

    logic [`RN_TAG_BITS-1:0]  specTagNext [`RN_ARCH_REGS];
    logic [`RN_ARCH_REGS-1:0] specAvailNext;
    logic [`RN_TAG_BITS-1:0]  comTagNext [`RN_ARCH_REGS];

    function automatic logic wbHit(input logic [`RN_TAG_BITS-1:0] tag);
        logic hit;
        hit = 1'b0;
        for (int w = 0; w < `RN_WB; w++) begin
            if (wb[w].valid && wb[w].tagDst == tag)
                hit = 1'b1;
        end
        return hit;
    endfunction

    always_comb begin
        for (int s = 0; s < 2*`RN_WIDTH; s++) begin
            lookupTags[s] = specTag[lookupRegs[s]];
            lookupAvail[s] = specAvail[lookupRegs[s]] || wbHit(specTag[lookupRegs[s]]);

            // An older slot of the same group renames this register first
            for (int k = 0; k < s / 2; k++) begin
                if (issueValid[k] && issueRegs[k] == lookupRegs[s]) begin
                    lookupTags[s] = issueTags[k];
                    lookupAvail[s] = 1'b0;
                end
            end

            if (lookupRegs[s] == '0) begin
                lookupTags[s] = '0;
                lookupAvail[s] = 1'b1;
            end
        end
    end

    // Previous tags come from the map before this cycle's commits
    always_comb begin
        for (int c = 0; c < `RN_WIDTH; c++)
            commitPrevTags[c] = comTag[commitRegs[c]];
    end

    always_comb begin
        comTagNext = comTag;
        for (int c = 0; c < `RN_WIDTH; c++) begin
            if (commitValid[c])
                comTagNext[commitRegs[c]] = commitTags[c];
        end

        // Committed results are all written back
        if (mispred) begin
            specTagNext = comTagNext;
            specAvailNext = '1;
        end else begin
            specTagNext = specTag;
            specAvailNext = specAvail;
            for (int i = 0; i < `RN_WIDTH; i++) begin
                if (issueValid[i]) begin
                    specTagNext[issueRegs[i]] = issueTags[i];
                    specAvailNext[issueRegs[i]] = 1'b0;
                end
            end
        end

        for (int r = 0; r < `RN_ARCH_REGS; r++) begin
            if (wbHit(specTagNext[r]))
                specAvailNext[r] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity mapping with every register ready
            for (int r = 0; r < `RN_ARCH_REGS; r++) begin
                specTag[r] <= `RN_TAG_BITS'(r);
                comTag[r] <= `RN_TAG_BITS'(r);
            end
            specAvail <= '1;
        end else begin
            specTag <= specTagNext;
            specAvail <= specAvailNext;
            comTag <= comTagNext;
        end
    end

endmodule

// File: rename/tagFreeList.sv
`timescale 1ns/100ps
`include "rename_defines.svh"

module tagFreeList (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    mispred,

    input  logic [`RN_WIDTH-1:0]    allocValid,
    output logic [`RN_TAG_BITS-1:0] allocTags [`RN_WIDTH],
    output logic                    enough,

    input  logic [`RN_WIDTH-1:0]    commitValid,
    input  logic [`RN_WIDTH-1:0]    commitNewest,
    input  logic [`RN_TAG_BITS-1:0] commitPrevTags [`RN_WIDTH],
    input  logic [`RN_TAG_BITS-1:0] commitTags [`RN_WIDTH]
);

    logic [`RN_TAGS-1:0] used;
    logic [`RN_TAGS-1:0] committed;
    logic [`RN_TAGS-1:0] usedNext;
    logic [`RN_TAGS-1:0] committedNext;

    // Lowest free tag per slot, skipping tags taken by older slots
    always_comb begin
        logic [`RN_TAGS-1:0] taken;
        logic found;
        taken = used;
        for (int s = 0; s < `RN_WIDTH; s++) begin
            allocTags[s] = '0;
            found = 1'b0;
            for (int t = 0; t < `RN_TAGS; t++) begin
                if (!found && !taken[t]) begin
                    allocTags[s] = `RN_TAG_BITS'(t);
                    found = 1'b1;
                end
            end
            if (allocValid[s])
                taken[allocTags[s]] = 1'b1;
        end
    end

    always_comb begin
        int freeCount;
        freeCount = 0;
        for (int t = 0; t < `RN_TAGS; t++) begin
            if (!used[t])
                freeCount++;
        end
        enough = freeCount >= `RN_WIDTH;
    end

    always_comb begin
        usedNext = used;
        committedNext = committed;
        for (int s = 0; s < `RN_WIDTH; s++) begin
            if (allocValid[s])
                usedNext[allocTags[s]] = 1'b1;
        end

        for (int c = 0; c < `RN_WIDTH; c++) begin
            if (commitValid[c]) begin
                if (commitNewest[c]) begin
                    usedNext[commitPrevTags[c]] = 1'b0;
                    committedNext[commitPrevTags[c]] = 1'b0;
                    committedNext[commitTags[c]] = 1'b1;
                end else begin
                    // Overwritten by a younger commit of the same group
                    usedNext[commitTags[c]] = 1'b0;
                    committedNext[commitTags[c]] = 1'b0;
                end
            end
        end

        // Drop every speculative allocation
        if (mispred)
            usedNext = committedNext;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            used <= {{(`RN_TAGS-`RN_ARCH_REGS){1'b0}}, {`RN_ARCH_REGS{1'b1}}};
            committed <= {{(`RN_TAGS-`RN_ARCH_REGS){1'b0}}, {`RN_ARCH_REGS{1'b1}}};
        end else begin
            used <= usedNext;
            committed <= committedNext;
        end
    end

endmodule

// File: rename/renameStage.sv
`timescale 1ns/100ps
`include "rename_defines.svh"

module renameStage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      en,
    input  logic                      frontEn,

    input  uopPkg::decodedUop         inUop [`RN_WIDTH],
    input  backendPkg::commitUop      comUop [`RN_WIDTH],
    input  backendPkg::wbResult       wb [`RN_WB],
    input  backendPkg::branchRecovery branch,

    output logic [`RN_WIDTH-1:0]      outValid,
    output uopPkg::renamedUop         outUop [`RN_WIDTH],
    output logic [`RN_SQN_BITS-1:0]   nextSqN,
    output logic [`RN_SQN_BITS-1:0]   nextLoadSqN,
    output logic [`RN_SQN_BITS-1:0]   nextStoreSqN,
    output logic                      stall
);

    logic                    accept;
    logic                    enough;

    logic [`RN_REG_BITS-1:0] lookupRegs [2*`RN_WIDTH];
    logic [`RN_TAG_BITS-1:0] lookupTags [2*`RN_WIDTH];
    logic [2*`RN_WIDTH-1:0]  lookupAvail;
    logic [`RN_WIDTH-1:0]    issueValid;
    logic [`RN_REG_BITS-1:0] issueRegs [`RN_WIDTH];
    logic [`RN_TAG_BITS-1:0] newTags [`RN_WIDTH];

    logic [`RN_WIDTH-1:0]    commitValid;
    logic [`RN_WIDTH-1:0]    commitNewest;
    logic [`RN_REG_BITS-1:0] commitRegs [`RN_WIDTH];
    logic [`RN_TAG_BITS-1:0] commitTags [`RN_WIDTH];
    logic [`RN_TAG_BITS-1:0] commitPrevTags [`RN_WIDTH];

    logic [`RN_SQN_BITS-1:0] counterSqN;
    logic [`RN_SQN_BITS-1:0] counterLoadSqN;
    logic [`RN_SQN_BITS-1:0] counterStoreSqN;
    logic [`RN_SQN_BITS-1:0] sqNNext;
    logic [`RN_SQN_BITS-1:0] loadSqNNext;
    logic [`RN_SQN_BITS-1:0] storeSqNNext;

    uopPkg::renamedUop       renamed [`RN_WIDTH];

    assign stall = !enough;
    assign accept = en && frontEn && !stall && !branch.taken && !rst;

    assign nextSqN = counterSqN;
    assign nextLoadSqN = counterLoadSqN;
    assign nextStoreSqN = counterStoreSqN + 1'b1;

    always_comb begin
        logic signed [`RN_SQN_BITS-1:0] age;
        for (int c = 0; c < `RN_WIDTH; c++) begin
            // Commits past the mispredicted branch are squashed
            age = comUop[c].sqN - branch.sqN;
            commitValid[c] = comUop[c].valid && comUop[c].nmDst != '0
                && (!branch.taken || age <= 0);
            commitRegs[c] = comUop[c].nmDst;
            commitTags[c] = comUop[c].tagDst;
        end
        for (int c = 0; c < `RN_WIDTH; c++) begin
            commitNewest[c] = commitValid[c];
            for (int k = c + 1; k < `RN_WIDTH; k++) begin
                if (commitValid[k] && commitRegs[k] == commitRegs[c])
                    commitNewest[c] = 1'b0;
            end
        end
    end

    always_comb begin
        sqNNext = counterSqN;
        loadSqNNext = counterLoadSqN;
        storeSqNNext = counterStoreSqN;
        for (int i = 0; i < `RN_WIDTH; i++) begin
            lookupRegs[2*i] = inUop[i].rs0;
            lookupRegs[2*i+1] = inUop[i].rs1;
            issueRegs[i] = inUop[i].rd;
            issueValid[i] = accept && inUop[i].valid && inUop[i].rd != '0;

            renamed[i].pc = inUop[i].pc;
            renamed[i].imm = inUop[i].imm;
            renamed[i].fu = inUop[i].fu;
            renamed[i].opcode = inUop[i].opcode;
            renamed[i].nmDst = inUop[i].rd;
            renamed[i].tagA = lookupTags[2*i];
            renamed[i].tagB = lookupTags[2*i+1];
            renamed[i].availA = lookupAvail[2*i];
            renamed[i].availB = lookupAvail[2*i+1];
            renamed[i].tagDst = (inUop[i].rd != '0) ? newTags[i] : '0;

            // Load number is taken before the bump, store number after it
            renamed[i].sqN = sqNNext;
            renamed[i].loadSqN = loadSqNNext;
            if (inUop[i].valid && inUop[i].fu == uopPkg::FU_LSU) begin
                if (inUop[i].isStore)
                    storeSqNNext = storeSqNNext + 1'b1;
                else
                    loadSqNNext = loadSqNNext + 1'b1;
            end
            renamed[i].storeSqN = storeSqNNext;
            if (inUop[i].valid)
                sqNNext = sqNNext + 1'b1;
        end
    end

    renameTable rt (
        .clk(clk),
        .rst(rst),
        .mispred(branch.taken),
        .lookupRegs(lookupRegs),
        .lookupTags(lookupTags),
        .lookupAvail(lookupAvail),
        .issueValid(issueValid),
        .issueRegs(issueRegs),
        .issueTags(newTags),
        .commitValid(commitValid),
        .commitRegs(commitRegs),
        .commitTags(commitTags),
        .commitPrevTags(commitPrevTags),
        .wb(wb)
    );

    tagFreeList tfl (
        .clk(clk),
        .rst(rst),
        .mispred(branch.taken),
        .allocValid(issueValid),
        .allocTags(newTags),
        .enough(enough),
        .commitValid(commitValid),
        .commitNewest(commitNewest),
        .commitPrevTags(commitPrevTags),
        .commitTags(commitTags)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= '0;
            counterSqN <= '0;
            counterLoadSqN <= '0;
            counterStoreSqN <= '1;
        end else if (branch.taken) begin
            outValid <= '0;
            counterSqN <= branch.sqN + 1'b1;
            counterLoadSqN <= branch.loadSqN;
            counterStoreSqN <= branch.storeSqN;
        end else if (accept) begin
            for (int i = 0; i < `RN_WIDTH; i++) begin
                outValid[i] <= inUop[i].valid;
                outUop[i] <= renamed[i];
            end
            counterSqN <= sqNNext;
            counterLoadSqN <= loadSqNNext;
            counterStoreSqN <= storeSqNNext;
        end else if (!en || frontEn) begin
            outValid <= '0;
        end else begin
            // Held group waits for the frontend, keep its operands current
            for (int j = 0; j < `RN_WIDTH; j++) begin
                for (int w = 0; w < `RN_WB; w++) begin
                    if (outValid[j] && wb[w].valid) begin
                        if (outUop[j].tagA == wb[w].tagDst)
                            outUop[j].availA <= 1'b1;
                        if (outUop[j].tagB == wb[w].tagDst)
                            outUop[j].availB <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: tests/renameStage_chk.sv
`timescale 1ns/100ps
`include "rename_defines.svh"

module renameStageChk (
    input logic                      clk,
    input logic                      rst,
    input backendPkg::branchRecovery branch,
    input logic [`RN_WIDTH-1:0]      outValid,
    input uopPkg::renamedUop         outUop [`RN_WIDTH],
    input logic                      stall
);

    // Nothing leaves the stage right after reset or a flush
    flushClears: assert property (@(posedge clk) (rst || branch.taken) |=> outValid == '0)
        else $error("outValid set in the cycle after reset or mispredict");

    // Two slots, r0 destinations carry tag 0 and are left out
    uniqueDst: assert property (@(posedge clk) disable iff (rst)
        (outValid[0] && outValid[1] && outUop[0].tagDst != '0)
            |-> outUop[0].tagDst != outUop[1].tagDst)
        else $error("two valid slots share tagDst %h", outUop[0].tagDst);

    stallAfterReset: assert property (@(posedge clk) rst |=> !stall)
        else $error("stall still high one cycle after reset");

endmodule

bind renameStage renameStageChk chk (
    .clk(clk),
    .rst(rst),
    .branch(branch),
    .outValid(outValid),
    .outUop(outUop),
    .stall(stall)
);

// File: tests/renameStage_tb.sv
`timescale 1ns/100ps
`include "rename_defines.svh"

module renameStage_tb;

    localparam int ROWS = 11;
    localparam int TIMEOUT = 40;

    // One cycle of stimulus
    typedef struct packed {
        logic                                 en;
        logic                                 front;
        uopPkg::decodedUop [`RN_WIDTH-1:0]    uop;
        backendPkg::commitUop [`RN_WIDTH-1:0] com;
        backendPkg::wbResult [`RN_WB-1:0]     wb;
        backendPkg::branchRecovery            br;
    } stepRow;

    logic clk = 1'b0;
    logic rst;
    logic en;
    logic frontEn;
    uopPkg::decodedUop         inUop [`RN_WIDTH];
    backendPkg::commitUop      comUop [`RN_WIDTH];
    backendPkg::wbResult       wb [`RN_WB];
    backendPkg::branchRecovery branch;
    logic [`RN_WIDTH-1:0]      outValid;
    uopPkg::renamedUop         outUop [`RN_WIDTH];
    logic [`RN_SQN_BITS-1:0]   nextSqN;
    logic [`RN_SQN_BITS-1:0]   nextLoadSqN;
    logic [`RN_SQN_BITS-1:0]   nextStoreSqN;
    logic                      stall;

    integer seed = 32'he65165c8;
    stepRow steps [ROWS];

    // Reference model state
    logic [`RN_TAG_BITS-1:0]  mSpecTag [`RN_ARCH_REGS];
    logic [`RN_ARCH_REGS-1:0] mSpecRdy;
    logic [`RN_TAG_BITS-1:0]  mComTag [`RN_ARCH_REGS];
    logic [`RN_TAGS-1:0]      mUsed;
    logic [`RN_TAGS-1:0]      mCommitted;
    logic [`RN_SQN_BITS-1:0]  mSq;
    logic [`RN_SQN_BITS-1:0]  mLd;
    // Internal store counter that the DUT shows plus one
    logic [`RN_SQN_BITS-1:0]  mSt;
    logic [`RN_WIDTH-1:0]     mValid;
    uopPkg::renamedUop        mUop [`RN_WIDTH];

    renameStage uut (
        .clk(clk),
        .rst(rst),
        .en(en),
        .frontEn(frontEn),
        .inUop(inUop),
        .comUop(comUop),
        .wb(wb),
        .branch(branch),
        .outValid(outValid),
        .outUop(outUop),
        .nextSqN(nextSqN),
        .nextLoadSqN(nextLoadSqN),
        .nextStoreSqN(nextStoreSqN),
        .stall(stall)
    );

    always #50 clk = ~clk;

    task automatic reportFail(input string line);
        $display("%s", line);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic checkRenamed(input string name, input uopPkg::renamedUop got,
                                input uopPkg::renamedUop exp);
        if (got !== exp)
            reportFail($sformatf("FAIL %s got %h expected %h", name, got, exp));
    endtask

    task automatic checkValid(input string name, input logic [`RN_WIDTH-1:0] got,
                              input logic [`RN_WIDTH-1:0] exp);
        if (got !== exp)
            reportFail($sformatf("FAIL %s got %h expected %h", name, got, exp));
    endtask

    task automatic checkStall(input string name, input logic got, input logic exp);
        if (got !== exp)
            reportFail($sformatf("FAIL %s got %h expected %h", name, got, exp));
    endtask

    task automatic checkCounters(input string name, input logic [`RN_SQN_BITS-1:0] got,
                                 input logic [`RN_SQN_BITS-1:0] exp);
        if (got !== exp)
            reportFail($sformatf("FAIL %s got %h expected %h", name, got, exp));
    endtask

    function automatic uopPkg::decodedUop mkUop(input logic valid, input uopPkg::fuKind fu,
            input logic isStore, input logic [4:0] rs0, input logic [4:0] rs1,
            input logic [4:0] rd);
        uopPkg::decodedUop u;
        u.valid = valid;
        u.pc = $random(seed);
        u.imm = $random(seed);
        u.rs0 = rs0;
        u.rs1 = rs1;
        u.rd = rd;
        u.fu = fu;
        u.opcode = 4'($random(seed));
        u.isStore = isStore;
        return u;
    endfunction

    function automatic backendPkg::commitUop mkCom(input logic [4:0] nm,
            input logic [5:0] tag, input logic [5:0] sqN);
        return {1'b1, nm, tag, sqN};
    endfunction

    function automatic stepRow mkRow(input logic rowEn, input logic front,
            input uopPkg::decodedUop u0, input uopPkg::decodedUop u1,
            input backendPkg::commitUop c0, input backendPkg::commitUop c1,
            input logic [6:0] w0, input logic [6:0] w1, input logic [18:0] br);
        stepRow row;
        row.en = rowEn;
        row.front = front;
        row.uop[0] = u0;
        row.uop[1] = u1;
        row.com[0] = c0;
        row.com[1] = c1;
        row.wb[0] = w0;
        row.wb[1] = w1;
        row.br = br;
        return row;
    endfunction

    function automatic int freeCount();
        int n;
        n = 0;
        for (int t = 0; t < `RN_TAGS; t++)
            if (!mUsed[t])
                n++;
        return n;
    endfunction

    function automatic logic wbHit(input stepRow row, input logic [`RN_TAG_BITS-1:0] tag);
        logic hit;
        hit = 1'b0;
        for (int w = 0; w < `RN_WB; w++)
            if (row.wb[w].valid && row.wb[w].tagDst == tag)
                hit = 1'b1;
        return hit;
    endfunction

    task automatic modelReset();
        for (int r = 0; r < `RN_ARCH_REGS; r++) begin
            mSpecTag[r] = `RN_TAG_BITS'(r);
            mComTag[r] = `RN_TAG_BITS'(r);
        end
        mSpecRdy = '1;
        mUsed = '0;
        for (int t = 0; t < `RN_ARCH_REGS; t++)
            mUsed[t] = 1'b1;
        mCommitted = mUsed;
        mSq = '0;
        mLd = '0;
        mSt = '1;
        mValid = '0;
    endtask

    // Advance the model by one clock edge with the inputs of this row
    task automatic modelStep(input stepRow row);
        logic accept;
        logic found;
        logic rdy;
        logic signed [`RN_SQN_BITS-1:0] age;
        logic [`RN_WIDTH-1:0] comOk;
        logic [`RN_WIDTH-1:0] newest;
        logic [`RN_REG_BITS-1:0] src;
        logic [`RN_REG_BITS-1:0] nm;
        logic [`RN_TAG_BITS-1:0] tag;
        logic [`RN_TAG_BITS-1:0] prev [`RN_WIDTH];
        logic [`RN_TAG_BITS-1:0] dstTag [`RN_WIDTH];
        logic [`RN_SQN_BITS-1:0] sq;
        logic [`RN_SQN_BITS-1:0] ld;
        logic [`RN_SQN_BITS-1:0] st;
        uopPkg::renamedUop ru [`RN_WIDTH];
        accept = row.en && row.front && freeCount() >= `RN_WIDTH && !row.br.taken;
        sq = mSq;
        ld = mLd;
        st = mSt;
        for (int i = 0; i < `RN_WIDTH; i++) begin
            ru[i] = '0;
            ru[i].pc = row.uop[i].pc;
            ru[i].imm = row.uop[i].imm;
            ru[i].fu = row.uop[i].fu;
            ru[i].opcode = row.uop[i].opcode;
            ru[i].nmDst = row.uop[i].rd;
            for (int k = 0; k < 2; k++) begin
                src = (k == 0) ? row.uop[i].rs0 : row.uop[i].rs1;
                tag = mSpecTag[src];
                rdy = mSpecRdy[src] || wbHit(row, tag);
                for (int j = 0; j < i; j++)
                    if (row.uop[j].valid && row.uop[j].rd != '0 && row.uop[j].rd == src) begin
                        tag = dstTag[j];
                        rdy = 1'b0;
                    end
                if (src == '0) begin
                    tag = '0;
                    rdy = 1'b1;
                end
                if (k == 0) begin
                    ru[i].tagA = tag;
                    ru[i].availA = rdy;
                end else begin
                    ru[i].tagB = tag;
                    ru[i].availB = rdy;
                end
            end
            dstTag[i] = '0;
            if (accept && row.uop[i].valid && row.uop[i].rd != '0) begin
                found = 1'b0;
                for (int t = 0; t < `RN_TAGS; t++)
                    if (!found && !mUsed[t]) begin
                        dstTag[i] = `RN_TAG_BITS'(t);
                        found = 1'b1;
                    end
                mUsed[dstTag[i]] = 1'b1;
            end
            ru[i].tagDst = dstTag[i];
            ru[i].sqN = sq;
            ru[i].loadSqN = ld;
            if (row.uop[i].valid && row.uop[i].fu == uopPkg::FU_LSU) begin
                if (row.uop[i].isStore)
                    st++;
                else
                    ld++;
            end
            ru[i].storeSqN = st;
            if (row.uop[i].valid)
                sq++;
        end

        for (int c = 0; c < `RN_WIDTH; c++) begin
            age = row.com[c].sqN - row.br.sqN;
            comOk[c] = row.com[c].valid && row.com[c].nmDst != '0
                && !(row.br.taken && age > 0);
            prev[c] = mComTag[row.com[c].nmDst];
        end
        for (int c = 0; c < `RN_WIDTH; c++) begin
            newest[c] = comOk[c];
            for (int k = c + 1; k < `RN_WIDTH; k++)
                if (comOk[k] && row.com[k].nmDst == row.com[c].nmDst)
                    newest[c] = 1'b0;
            nm = row.com[c].nmDst;
            tag = row.com[c].tagDst;
            if (comOk[c]) begin
                if (newest[c]) begin
                    mUsed[prev[c]] = 1'b0;
                    mCommitted[prev[c]] = 1'b0;
                    mCommitted[tag] = 1'b1;
                end else begin
                    mUsed[tag] = 1'b0;
                    mCommitted[tag] = 1'b0;
                end
                mComTag[nm] = tag;
            end
        end

        // Committed registers are all ready
        if (row.br.taken) begin
            mSpecTag = mComTag;
            mSpecRdy = '1;
            mUsed = mCommitted;
        end else begin
            for (int i = 0; i < `RN_WIDTH; i++)
                if (dstTag[i] != '0) begin
                    mSpecTag[row.uop[i].rd] = dstTag[i];
                    mSpecRdy[row.uop[i].rd] = 1'b0;
                end
        end
        for (int r = 0; r < `RN_ARCH_REGS; r++) begin
            if (wbHit(row, mSpecTag[r]))
                mSpecRdy[r] = 1'b1;
        end

        if (row.br.taken) begin
            mValid = '0;
            mSq = row.br.sqN + 1'b1;
            mLd = row.br.loadSqN;
            mSt = row.br.storeSqN;
        end else if (accept) begin
            for (int i = 0; i < `RN_WIDTH; i++) begin
                mValid[i] = row.uop[i].valid;
                mUop[i] = ru[i];
            end
            mSq = sq;
            mLd = ld;
            mSt = st;
        end else if (!row.en || row.front) begin
            mValid = '0;
        end else begin
            for (int j = 0; j < `RN_WIDTH; j++) begin
                if (mValid[j] && wbHit(row, mUop[j].tagA))
                    mUop[j].availA = 1'b1;
                if (mValid[j] && wbHit(row, mUop[j].tagB))
                    mUop[j].availB = 1'b1;
            end
        end
    endtask

    task automatic checkOutputs();
        checkValid("outValid", outValid, mValid);
        for (int i = 0; i < `RN_WIDTH; i++)
            if (mValid[i])
                checkRenamed($sformatf("outUop[%0d]", i), outUop[i], mUop[i]);
        checkCounters("nextSqN", nextSqN, mSq);
        checkCounters("nextLoadSqN", nextLoadSqN, mLd);
        checkCounters("nextStoreSqN", nextStoreSqN, mSt + 1'b1);
    endtask

    // Starts on a falling edge and returns on the next one
    task automatic applyRow(input stepRow row);
        en = row.en;
        frontEn = row.front;
        for (int i = 0; i < `RN_WIDTH; i++) begin
            inUop[i] = row.uop[i];
            comUop[i] = row.com[i];
        end
        for (int w = 0; w < `RN_WB; w++)
            wb[w] = row.wb[w];
        branch = row.br;
        checkStall("stall", stall, freeCount() < `RN_WIDTH);
        modelStep(row);
        @(posedge clk);
        @(negedge clk);
        checkOutputs();
    endtask

    task automatic fillTable();
        // Reads r1 to r4 straight after reset
        steps[0] = mkRow(1, 1, mkUop(1, uopPkg::FU_INT, 0, 1, 2, 0),
            mkUop(1, uopPkg::FU_INT, 0, 3, 4, 0), '0, '0, '0, '0, '0);
        // Slot 1 reads the rd of slot 0
        steps[1] = mkRow(1, 1, mkUop(1, uopPkg::FU_INT, 0, 1, 2, 5),
            mkUop(1, uopPkg::FU_INT, 0, 5, 0, 6), '0, '0, '0, '0, '0);
        steps[2] = mkRow(1, 1, mkUop(1, uopPkg::FU_MUL, 0, 6, 5, 0),
            mkUop(1, uopPkg::FU_INT, 0, 1, 2, 7), '0, '0, '0, '0, '0);
        // Frontend holds while tag 33 writes back
        steps[3] = mkRow(1, 0, mkUop(1, uopPkg::FU_INT, 0, 1, 1, 0),
            mkUop(1, uopPkg::FU_INT, 0, 2, 2, 0), '0, '0, {1'b1, 6'd33}, '0, '0);
        // Load then store with tag 34 forwarded in the same cycle
        steps[4] = mkRow(1, 1, mkUop(1, uopPkg::FU_LSU, 0, 6, 5, 0),
            mkUop(1, uopPkg::FU_LSU, 1, 6, 7, 0), '0, '0, '0, {1'b1, 6'd34}, '0);
        steps[5] = mkRow(1, 1, mkUop(1, uopPkg::FU_LSU, 1, 1, 2, 0),
            mkUop(1, uopPkg::FU_LSU, 0, 3, 0, 8), '0, '0, '0, '0, '0);
        steps[6] = mkRow(1, 1, mkUop(0, uopPkg::FU_INT, 0, 0, 0, 0),
            mkUop(1, uopPkg::FU_BRANCH, 0, 8, 0, 9), '0, '0, '0, '0, '0);
        // Retire r5 and r6 with the pipeline disabled
        steps[7] = mkRow(0, 1, '0, '0, mkCom(5, 32, 2), mkCom(6, 33, 3), '0, '0, '0);
        steps[8] = mkRow(1, 1, mkUop(1, uopPkg::FU_INT, 0, 5, 6, 10),
            mkUop(1, uopPkg::FU_INT, 0, 10, 0, 11), mkCom(7, 34, 5), '0, '0, '0, '0);
        // Mispredict at sqN 7 squashes the younger commit at sqN 9
        steps[9] = mkRow(1, 1, mkUop(1, uopPkg::FU_INT, 0, 1, 2, 3),
            mkUop(1, uopPkg::FU_INT, 0, 3, 4, 5), mkCom(8, 35, 9), '0, '0, '0,
            {1'b1, 6'd7, 6'd1, 6'd0});
        steps[10] = mkRow(1, 1, mkUop(1, uopPkg::FU_INT, 0, 5, 6, 12),
            mkUop(1, uopPkg::FU_LSU, 1, 7, 8, 13), '0, '0, '0, '0, '0);
    endtask

    task automatic fillUntilStall();
        stepRow row;
        int n;
        n = 0;
        while (stall !== 1'b1) begin
            if (n == TIMEOUT)
                reportFail("Timed out waiting for stall to rise");
            row = mkRow(1, 1, mkUop(1, uopPkg::FU_INT, 0, 0, 0, 1),
                mkUop(1, uopPkg::FU_MUL, 0, 0, 0, 2), '0, '0, '0, '0, '0);
            applyRow(row);
            n++;
        end
        // One more group must be refused
        applyRow(row);
    endtask

    initial begin
        int n;
        rst = 1'b1;
        en = 1'b0;
        frontEn = 1'b0;
        for (int i = 0; i < `RN_WIDTH; i++) begin
            inUop[i] = '0;
            comUop[i] = '0;
        end
        for (int w = 0; w < `RN_WB; w++)
            wb[w] = '0;
        branch = '0;
        modelReset();
        fillTable();

        repeat (10) @(negedge clk);
        rst = 1'b0;
        n = 0;
        while (stall !== 1'b0) begin
            if (n == TIMEOUT)
                reportFail("Timed out waiting for stall to go low after reset");
            @(negedge clk);
            n++;
        end
        checkOutputs();

        for (int r = 0; r < ROWS; r++)
            applyRow(steps[r]);
        fillUntilStall();

        $display("** PASS **");
        $finish;
    end

endmodule

// File: renameStage.f
+incdir+common
common/uopPkg.sv
common/backendPkg.sv
rename/renameTable.sv
rename/tagFreeList.sv
rename/renameStage.sv
tests/renameStage_chk.sv
tests/renameStage_tb.sv

// File: Bender.yml
package:
  name: renameStage

export_include_dirs:
  - common

sources:
  - files:
      - common/uopPkg.sv
      - common/backendPkg.sv
      - rename/renameTable.sv
      - rename/tagFreeList.sv
      - rename/renameStage.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/renameStage_chk.sv
      - tests/renameStage_tb.sv
